//--- hdl/axiLiteRegs.sv
`default_nettype none
`include "melody_consts.svh"

module axiLiteRegs (
	input wire logic Clock,
	input wire logic reset_i,
	input wire melodyPkg::axiLiteReqT axiReq_i,
	output melodyPkg::axiLiteRespT axiResp_o,
	input wire logic done_i,
	input wire melodyPkg::statusT status_i,
	input wire melodyPkg::noteT note_i,
	output melodyPkg::controlT control_o
);

	melodyPkg::regSelE writeSel;
	melodyPkg::regSelE readSel;
	melodyPkg::controlT nextControl;
	logic writeFire;
	logic readFire;
	logic bvalid;
	logic rvalid;
	logic [1:0] bresp;
	logic [1:0] rresp;
	logic [1:0] readResp;
	logic [`AXIL_DATA_W-1:0] rdata;
	logic [`AXIL_DATA_W-1:0] readData;
	logic [`AXIL_DATA_W-1:0] ctrlWord;

	function automatic melodyPkg::regSelE decodeAddr(input logic [`AXIL_ADDR_W-1:0] addr);
		case (addr)
			`REG_CONTROL: return melodyPkg::REG_SEL_CONTROL;
			`REG_STATUS: return melodyPkg::REG_SEL_STATUS;
			`REG_NOTE: return melodyPkg::REG_SEL_NOTE;
			default: return melodyPkg::REG_SEL_NONE;
		endcase
	endfunction

	function automatic logic [`AXIL_DATA_W-1:0] controlToWord(input melodyPkg::controlT c);
		logic [`AXIL_DATA_W-1:0] w;
		w = '0;
		w[0] = c.play;
		w[1] = c.loop;
		w[13:8] = c.firstNote;
		w[21:16] = c.lastNote;
		return w;
	endfunction

	function automatic melodyPkg::controlT wordToControl(input logic [`AXIL_DATA_W-1:0] w);
		melodyPkg::controlT c;
		c.play = w[0];
		c.loop = w[1];
		c.firstNote = w[13:8];
		c.lastNote = w[21:16];
		return c;
	endfunction

	// AW and W are taken together, one response outstanding per channel
	assign writeFire = axiReq_i.awvalid && axiReq_i.wvalid && !bvalid;
	assign readFire = axiReq_i.arvalid && !rvalid;
	assign writeSel = decodeAddr(axiReq_i.awaddr);
	assign readSel = decodeAddr(axiReq_i.araddr);

	always_comb begin
		ctrlWord = controlToWord(control_o);
		// end of range drops play before any new write lands
		if (done_i)
			ctrlWord[0] = 1'b0;
		for (int lane = 0; lane < `AXIL_DATA_W / 8; lane++) begin
			if (writeFire && writeSel == melodyPkg::REG_SEL_CONTROL && axiReq_i.wstrb[lane])
				ctrlWord[lane*8 +: 8] = axiReq_i.wdata[lane*8 +: 8];
		end
		nextControl = wordToControl(ctrlWord);
	end

	always_comb begin
		readData = '0;
		readResp = `AXIL_RESP_OKAY;
		case (readSel)
			melodyPkg::REG_SEL_CONTROL: readData = controlToWord(control_o);
			melodyPkg::REG_SEL_STATUS: begin
				readData[0] = status_i.busy;
				readData[13:8] = status_i.noteIndex;
			end
			melodyPkg::REG_SEL_NOTE: readData = note_i;
			default: readResp = `AXIL_RESP_SLVERR;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (reset_i) begin
			control_o <= '0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			control_o <= nextControl;
			if (writeFire)
				bvalid <= 1'b1;
			else if (axiReq_i.bready)
				bvalid <= 1'b0;
			if (readFire)
				rvalid <= 1'b1;
			else if (axiReq_i.rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge Clock) begin
		if (writeFire)
			bresp <= (writeSel == melodyPkg::REG_SEL_CONTROL) ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR;
		if (readFire) begin
			rdata <= readData;
			rresp <= readResp;
		end
	end

	always_comb begin
		axiResp_o.awready = !bvalid;
		axiResp_o.wready = !bvalid;
		axiResp_o.bresp = bresp;
		axiResp_o.bvalid = bvalid;
		axiResp_o.arready = !rvalid;
		axiResp_o.rdata = rdata;
		axiResp_o.rresp = rresp;
		axiResp_o.rvalid = rvalid;
	end

	bValidHeld: assert property (@(posedge Clock) disable iff (reset_i)
		bvalid && !axiReq_i.bready |=> bvalid);
	rValidHeld: assert property (@(posedge Clock) disable iff (reset_i)
		rvalid && !axiReq_i.rready |=> rvalid);

endmodule

`default_nettype wire

//--- hdl/melodyPkg.sv
`default_nettype none
`include "melody_consts.svh"

package melodyPkg;

	// one table entry, duration in the upper half
	typedef struct packed {
		logic [15:0] durationMs;
		logic [15:0] halfPeriodUs;
	} noteT;

	typedef struct packed {
		logic play;
		logic loop;
		logic [`MELODY_NOTE_W-1:0] firstNote;
		logic [`MELODY_NOTE_W-1:0] lastNote;
	} controlT;

	typedef struct packed {
		logic busy;
		logic [`MELODY_NOTE_W-1:0] noteIndex;
	} statusT;

	typedef struct packed {
		logic [`AXIL_ADDR_W-1:0] awaddr;
		logic awvalid;
		logic [`AXIL_DATA_W-1:0] wdata;
		logic [`AXIL_DATA_W/8-1:0] wstrb;
		logic wvalid;
		logic bready;
		logic [`AXIL_ADDR_W-1:0] araddr;
		logic arvalid;
		logic rready;
	} axiLiteReqT;

	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [`AXIL_DATA_W-1:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axiLiteRespT;

	typedef enum logic [1:0] {SEQ_IDLE, SEQ_FETCH, SEQ_PLAY} seqStateE;

	typedef enum logic [1:0] {
		REG_SEL_CONTROL,
		REG_SEL_STATUS,
		REG_SEL_NOTE,
		REG_SEL_NONE
	} regSelE;

endpackage

`default_nettype wire

//--- hdl/melodyPlayer.sv
`default_nettype none

module melodyPlayer #(
	parameter int ClocksPerUs = 50,
	parameter int UsPerMs = 1000
) (
	input wire logic Clock,
	input wire logic reset_i,
	input wire melodyPkg::axiLiteReqT axiReq_i,
	output melodyPkg::axiLiteRespT axiResp_o,
	output logic tone_o
);

	melodyPkg::controlT control;
	melodyPkg::statusT status;
	melodyPkg::noteT note;
	logic done;
	logic playing;
	logic noteStart;
	logic usTick;

	axiLiteRegs regs (
		.Clock(Clock),
		.reset_i(reset_i),
		.axiReq_i(axiReq_i),
		.axiResp_o(axiResp_o),
		.done_i(done),
		.status_i(status),
		.note_i(note),
		.control_o(control)
	);

	noteSequencer #(
		.ClocksPerUs(ClocksPerUs),
		.UsPerMs(UsPerMs)
	) sequencer (
		.Clock(Clock),
		.reset_i(reset_i),
		.control_i(control),
		.done_o(done),
		.status_o(status),
		.note_o(note),
		.playing_o(playing),
		.noteStart_o(noteStart),
		.usTick_o(usTick)
	);

	toneGenerator tone (
		.Clock(Clock),
		.reset_i(reset_i),
		.note_i(note),
		.playing_i(playing),
		.noteStart_i(noteStart),
		.usTick_i(usTick),
		.tone_o(tone_o)
	);

endmodule

`default_nettype wire

//--- hdl/melody_consts.svh
`ifndef MELODY_CONSTS_SVH
`define MELODY_CONSTS_SVH

// note table geometry
`define MELODY_NOTE_COUNT 50
`define MELODY_ROM_ADDR_W 12
`define MELODY_NOTE_W 6

// register bus
`define AXIL_ADDR_W 4
`define AXIL_DATA_W 32
`define REG_CONTROL 4'h0
`define REG_STATUS 4'h4
`define REG_NOTE 4'h8
`define AXIL_RESP_OKAY 2'd0
`define AXIL_RESP_SLVERR 2'd2

`endif

//--- hdl/noteRom.sv
`default_nettype none
`include "melody_consts.svh"

module noteRom (
	input wire logic Clock,
	input wire logic reset_i,
	input wire logic ReadEnable_i,
	input wire logic [`MELODY_ROM_ADDR_W-1:0] Address_i,
	output logic [7:0] Data_o
);

	logic [31:0] noteWord;
	logic [1:0] byteSel;

	// each entry is {durationMs, halfPeriodUs}, read out high byte first
	always_comb begin
		case (Address_i[`MELODY_ROM_ADDR_W-1:2])
			10'd0: noteWord = 32'h01F4_0470;
			10'd1: noteWord = 32'h01F4_0470;
			10'd2: noteWord = 32'h01F4_0470;
			10'd3: noteWord = 32'h01F4_0597;
			10'd4: noteWord = 32'h007D_03BB;
			10'd5: noteWord = 32'h01F4_0470;
			10'd6: noteWord = 32'h01F4_0597;
			10'd7: noteWord = 32'h007D_03BB;
			10'd8: noteWord = 32'h03E8_0470;
			10'd9: noteWord = 32'h01F4_02F6;
			10'd10: noteWord = 32'h01F4_02F6;
			10'd11: noteWord = 32'h01F4_02F6;
			10'd12: noteWord = 32'h01F4_02CB;
			10'd13: noteWord = 32'h007D_03BB;
			10'd14: noteWord = 32'h01F4_04B3;
			10'd15: noteWord = 32'h01F4_0597;
			10'd16: noteWord = 32'h007D_03BB;
			10'd17: noteWord = 32'h03E8_0470;
			// second phrase
			10'd18: noteWord = 32'h01F4_0238;
			10'd19: noteWord = 32'h01F4_0470;
			10'd20: noteWord = 32'h007D_0470;
			10'd21: noteWord = 32'h01F4_0238;
			10'd22: noteWord = 32'h01F4_0259;
			10'd23: noteWord = 32'h007D_027D;
			10'd24: noteWord = 32'h007D_02A3;
			10'd25: noteWord = 32'h007D_02CB;
			10'd26: noteWord = 32'h01F4_02A3;
			10'd27: noteWord = 32'h00FA_0430;
			10'd28: noteWord = 32'h01F4_0323;
			10'd29: noteWord = 32'h01F4_0353;
			10'd30: noteWord = 32'h007D_0385;
			10'd31: noteWord = 32'h007D_03BB;
			10'd32: noteWord = 32'h007D_03F4;
			10'd33: noteWord = 32'h01F4_03BB;
			10'd34: noteWord = 32'h00FA_0597;
			10'd35: noteWord = 32'h01F4_04B3;
			10'd36: noteWord = 32'h01F4_0597;
			10'd37: noteWord = 32'h007D_04B3;
			10'd38: noteWord = 32'h01F4_03BB;
			10'd39: noteWord = 32'h01F4_0470;
			10'd40: noteWord = 32'h007D_03BB;
			10'd41: noteWord = 32'h03E8_02F6;
			10'd42: noteWord = 32'h01F4_0238;
			10'd43: noteWord = 32'h01F4_0470;
			10'd44: noteWord = 32'h007D_0470;
			10'd45: noteWord = 32'h01F4_0238;
			10'd46: noteWord = 32'h01F4_0259;
			10'd47: noteWord = 32'h007D_027D;
			10'd48: noteWord = 32'h007D_02A3;
			10'd49: noteWord = 32'h007D_02CB;
			default: noteWord = 32'h0000_0000;
		endcase
	end

	// byte 0 sits in the top lane
	assign byteSel = ~Address_i[1:0];

	always_ff @(posedge Clock) begin
		if (reset_i)
			Data_o <= 8'h00;
		else if (ReadEnable_i)
			Data_o <= noteWord[{byteSel, 3'b000} +: 8];
	end

endmodule

`default_nettype wire

//--- hdl/noteSequencer.sv
`default_nettype none
`include "melody_consts.svh"

module noteSequencer #(
	parameter int ClocksPerUs = 50,
	parameter int UsPerMs = 1000
) (
	input wire logic Clock,
	input wire logic reset_i,
	input wire melodyPkg::controlT control_i,
	output logic done_o,
	output melodyPkg::statusT status_o,
	output melodyPkg::noteT note_o,
	output logic playing_o,
	output logic noteStart_o,
	output logic usTick_o
);

	localparam int UsCntW = $clog2(ClocksPerUs + 1);
	localparam int MsCntW = $clog2(UsPerMs + 1);

	melodyPkg::seqStateE state;
	logic [`MELODY_NOTE_W-1:0] noteIndex;
	logic [`MELODY_NOTE_W-1:0] nextIndex;
	logic [`MELODY_NOTE_W-1:0] startIndex;
	logic [2:0] fetchCnt;
	logic [23:0] fetchShift;
	logic romReadEnable;
	logic [`MELODY_ROM_ADDR_W-1:0] romAddr;
	logic [7:0] romData;
	logic [UsCntW-1:0] usCnt;
	logic [MsCntW-1:0] msCnt;
	logic [15:0] msLeft;
	logic msTick;
	logic noteEnd;
	logic lastInRange;

	noteRom rom (
		.Clock(Clock),
		.reset_i(reset_i),
		.ReadEnable_i(romReadEnable),
		.Address_i(romAddr),
		.Data_o(romData)
	);

	// out-of-table first index falls back to note 0
	assign startIndex = (control_i.firstNote < `MELODY_NOTE_COUNT) ? control_i.firstNote : '0;
	assign nextIndex = (noteIndex == `MELODY_NOTE_COUNT - 1) ? '0 : noteIndex + 1'b1;
	assign lastInRange = (noteIndex == control_i.lastNote);

	assign romReadEnable = (state == melodyPkg::SEQ_FETCH) && !fetchCnt[2];
	assign romAddr = {{(`MELODY_ROM_ADDR_W - `MELODY_NOTE_W - 2){1'b0}}, noteIndex, fetchCnt[1:0]};

	// timebase restarts with each note
	assign usTick_o = (state == melodyPkg::SEQ_PLAY) && (usCnt == UsCntW'(ClocksPerUs - 1));
	assign msTick = usTick_o && (msCnt == MsCntW'(UsPerMs - 1));
	assign noteEnd = msTick && (msLeft == 16'd1);
	assign done_o = noteEnd && lastInRange && !control_i.loop;

	assign playing_o = (state == melodyPkg::SEQ_PLAY);
	assign status_o.busy = (state != melodyPkg::SEQ_IDLE);
	assign status_o.noteIndex = noteIndex;

	always_ff @(posedge Clock) begin
		if (reset_i) begin
			state <= melodyPkg::SEQ_IDLE;
			noteIndex <= '0;
			fetchCnt <= '0;
			noteStart_o <= 1'b0;
			note_o <= '0;
			usCnt <= '0;
			msCnt <= '0;
			msLeft <= '0;
		end else begin
			noteStart_o <= 1'b0;
			if (!control_i.play) begin
				state <= melodyPkg::SEQ_IDLE;
			end else begin
				case (state)
					melodyPkg::SEQ_IDLE: begin
						state <= melodyPkg::SEQ_FETCH;
						noteIndex <= startIndex;
						fetchCnt <= '0;
					end
					melodyPkg::SEQ_FETCH: begin
						fetchCnt <= fetchCnt + 3'd1;
						// last byte is on the ROM output now
						if (fetchCnt == 3'd4) begin
							state <= melodyPkg::SEQ_PLAY;
							noteStart_o <= 1'b1;
							note_o <= {fetchShift, romData};
							usCnt <= '0;
							msCnt <= '0;
							msLeft <= fetchShift[23:8];
						end
					end
					melodyPkg::SEQ_PLAY: begin
						usCnt <= usTick_o ? '0 : usCnt + 1'b1;
						if (usTick_o)
							msCnt <= msTick ? '0 : msCnt + 1'b1;
						if (msTick)
							msLeft <= msLeft - 16'd1;
						if (noteEnd) begin
							if (lastInRange && !control_i.loop) begin
								state <= melodyPkg::SEQ_IDLE;
							end else begin
								state <= melodyPkg::SEQ_FETCH;
								fetchCnt <= '0;
								noteIndex <= lastInRange ? startIndex : nextIndex;
							end
						end
					end
					default: state <= melodyPkg::SEQ_IDLE;
				endcase
			end
		end
	end

	// bytes arrive high first
	always_ff @(posedge Clock) begin
		if (state == melodyPkg::SEQ_FETCH)
			fetchShift <= {fetchShift[15:0], romData};
	end

	romAddrInTable: assert property (@(posedge Clock) disable iff (reset_i)
		romReadEnable |-> romAddr < 4 * `MELODY_NOTE_COUNT);

endmodule

`default_nettype wire

//--- hdl/toneGenerator.sv
`default_nettype none

module toneGenerator (
	input wire logic Clock,
	input wire logic reset_i,
	input wire melodyPkg::noteT note_i,
	input wire logic playing_i,
	input wire logic noteStart_i,
	input wire logic usTick_i,
	output logic tone_o
);

	logic [15:0] halfCnt;
	logic [15:0] remaining;
	logic toneBase;

	// a new note restarts the half period from low
	always_comb begin
		remaining = noteStart_i ? note_i.halfPeriodUs : halfCnt;
		toneBase = noteStart_i ? 1'b0 : tone_o;
	end

	always_ff @(posedge Clock) begin
		if (reset_i || !playing_i) begin
			halfCnt <= '0;
			tone_o <= 1'b0;
		end else if (usTick_i && remaining <= 16'd1) begin
			halfCnt <= note_i.halfPeriodUs;
			tone_o <= ~toneBase;
		end else begin
			halfCnt <= usTick_i ? remaining - 16'd1 : remaining;
			tone_o <= toneBase;
		end
	end

	toneLowWhenIdle: assert property (@(posedge Clock) disable iff (reset_i)
		!playing_i |=> !tone_o);

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/melodyPkg.sv
hdl/noteRom.sv
hdl/axiLiteRegs.sv
hdl/noteSequencer.sv
hdl/toneGenerator.sv
hdl/melodyPlayer.sv
verif/melodyPlayerTb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f list.f \
	--top-module melodyPlayerTb \
	-o melodyPlayerSim

./obj_dir/melodyPlayerSim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
exit 0

//--- verif/melodyPlayerTb.sv
`default_nettype none
`include "melody_consts.svh"

module melodyPlayerTb;

	localparam int ClocksPerUs = 1;
	localparam int UsPerMs = 50;
	localparam int HandshakeLimit = 100;
	// implemented CONTROL bits for lastNote, firstNote, loop and play
	localparam logic [31:0] ControlMask = 32'h003F_3F03;
	// notes 0, 3+4 and two rounds of 8, with fetches, plus margin
	localparam int WatchdogCycles = (5 + 500 * UsPerMs * ClocksPerUs)
		+ (10 + 625 * UsPerMs * ClocksPerUs)
		+ 2 * (5 + 1000 * UsPerMs * ClocksPerUs) + 20000;

	logic Clock = 1'b0;
	logic reset;
	melodyPkg::axiLiteReqT axiReq;
	melodyPkg::axiLiteRespT axiResp;
	logic tone;

	logic [31:0] lcgState;
	int cycleCount = 0;
	int busyRiseCycle;
	int busyFallCycle;
	int busyFalls = 0;
	logic busyPrev = 1'b0;
	logic tonePrev = 1'b0;
	int toneEdges[$];

	melodyPlayer #(
		.ClocksPerUs(ClocksPerUs),
		.UsPerMs(UsPerMs)
	) DUT (
		.Clock(Clock),
		.reset_i(reset),
		.axiReq_i(axiReq),
		.axiResp_o(axiResp),
		.tone_o(tone)
	);

	always #10 Clock = ~Clock;

	always @(posedge Clock)
		cycleCount <= cycleCount + 1;

	// busy and tone edges, sampled away from the active edge
	always @(negedge Clock) begin
		if (!reset) begin
			if (DUT.status.busy && !busyPrev)
				busyRiseCycle = cycleCount;
			if (!DUT.status.busy && busyPrev) begin
				busyFallCycle = cycleCount;
				busyFalls++;
			end
			if (tone != tonePrev)
				toneEdges.push_back(cycleCount);
		end
		busyPrev = DUT.status.busy;
		tonePrev = tone;
	end

	initial begin
		repeat (WatchdogCycles) @(posedge Clock);
		reportFailure("watchdog expired before the tests completed");
	end

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// reference copies of the table entries used below
	function automatic melodyPkg::noteT refNote(input int index);
		melodyPkg::noteT n;
		case (index)
			0: n = '{16'd500, 16'd1136};
			3: n = '{16'd500, 16'd1431};
			4: n = '{16'd125, 16'd955};
			8: n = '{16'd1000, 16'd1136};
			default: n = '0;
		endcase
		return n;
	endfunction

	function automatic int noteCycles(input melodyPkg::noteT n);
		return n.durationMs * UsPerMs * ClocksPerUs;
	endfunction

	function automatic melodyPkg::controlT unpackControl(input logic [31:0] w);
		melodyPkg::controlT c;
		c.play = w[0];
		c.loop = w[1];
		c.firstNote = w[13:8];
		c.lastNote = w[21:16];
		return c;
	endfunction

	function automatic melodyPkg::statusT unpackStatus(input logic [31:0] w);
		melodyPkg::statusT s;
		s.busy = w[0];
		s.noteIndex = w[13:8];
		return s;
	endfunction

	task automatic checkNote(input string name, input melodyPkg::noteT got,
			input melodyPkg::noteT exp);
		if (got !== exp)
			reportFailure($sformatf(
				"CHECK FAILED at %0t: %s got %0d/%0d expected %0d/%0d",
				$time, name, got.durationMs, got.halfPeriodUs,
				exp.durationMs, exp.halfPeriodUs));
	endtask

	task automatic checkStatus(input string name, input melodyPkg::statusT got,
			input melodyPkg::statusT exp);
		if (got !== exp)
			reportFailure($sformatf(
				"CHECK FAILED at %0t: %s got busy %b index %0d expected busy %b index %0d",
				$time, name, got.busy, got.noteIndex, exp.busy, exp.noteIndex));
	endtask

	task automatic checkControl(input string name, input melodyPkg::controlT got,
			input melodyPkg::controlT exp);
		if (got !== exp)
			reportFailure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic checkResp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			reportFailure($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
			reportFailure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic checkCycles(input string name, input int got, input int exp);
		if (got != exp)
			reportFailure($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic waitCycles(input int count);
		repeat (count) @(posedge Clock);
		#1;
	endtask

	task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int waitCount;
		axiReq.awaddr = addr;
		axiReq.wdata = data;
		axiReq.wstrb = strb;
		axiReq.awvalid = 1'b1;
		axiReq.wvalid = 1'b1;
		axiReq.bready = 1'b1;
		waitCount = 0;
		@(negedge Clock);
		while (!(axiResp.awready && axiResp.wready)) begin
			waitCount++;
			if (waitCount > HandshakeLimit)
				reportFailure("write address and data were never accepted");
			@(negedge Clock);
		end
		@(posedge Clock);
		#1;
		axiReq.awvalid = 1'b0;
		axiReq.wvalid = 1'b0;
		@(negedge Clock);
		if (!axiResp.bvalid)
			reportFailure("write response did not come one cycle after the handshake");
		resp = axiResp.bresp;
		@(posedge Clock);
		#1;
		axiReq.bready = 1'b0;
	endtask

	task automatic axiRead(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int waitCount;
		axiReq.araddr = addr;
		axiReq.arvalid = 1'b1;
		axiReq.rready = 1'b1;
		waitCount = 0;
		@(negedge Clock);
		while (!axiResp.arready) begin
			waitCount++;
			if (waitCount > HandshakeLimit)
				reportFailure("read address was never accepted");
			@(negedge Clock);
		end
		@(posedge Clock);
		#1;
		axiReq.arvalid = 1'b0;
		@(negedge Clock);
		if (!axiResp.rvalid)
			reportFailure("read data did not come one cycle after the handshake");
		data = axiResp.rdata;
		resp = axiResp.rresp;
		@(posedge Clock);
		#1;
		axiReq.rready = 1'b0;
	endtask

	task automatic waitIdle(input int limit);
		int count;
		count = 0;
		while (DUT.status.busy) begin
			@(negedge Clock);
			count++;
			if (count > limit)
				reportFailure("playback did not finish in time");
		end
		waitCycles(1);
	endtask

	task automatic readResetValues();
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(`REG_CONTROL, data, resp);
		checkResp("rresp CONTROL", resp, `AXIL_RESP_OKAY);
		checkControl("CONTROL", unpackControl(data), '0);
		axiRead(`REG_STATUS, data, resp);
		checkResp("rresp STATUS", resp, `AXIL_RESP_OKAY);
		checkStatus("STATUS", unpackStatus(data), '0);
		axiRead(`REG_NOTE, data, resp);
		checkResp("rresp NOTE", resp, `AXIL_RESP_OKAY);
		checkNote("NOTE", melodyPkg::noteT'(data), '0);
		checkBit("tone_o", tone, 1'b0);
	endtask

	task automatic mergeControlLanes();
		logic [31:0] shadow;
		logic [31:0] wdata;
		logic [31:0] laneMask;
		logic [31:0] data;
		logic [31:0] r;
		logic [3:0] strb;
		logic [1:0] resp;
		shadow = '0;
		for (int i = 0; i < 8; i++) begin
			wdata = nextRandom() & ~32'h1;
			r = nextRandom();
			strb = r[3:0];
			if (strb == 4'hF)
				strb = 4'h6;
			laneMask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
			shadow = ((shadow & ~laneMask) | (wdata & laneMask)) & ControlMask;
			axiWrite(`REG_CONTROL, wdata, strb, resp);
			checkResp("bresp CONTROL", resp, `AXIL_RESP_OKAY);
			axiRead(`REG_CONTROL, data, resp);
			checkResp("rresp CONTROL", resp, `AXIL_RESP_OKAY);
			checkControl("CONTROL", unpackControl(data), unpackControl(shadow));
		end
		axiWrite(`REG_STATUS, 32'hFFFF_FFFF, 4'hF, resp);
		checkResp("bresp STATUS", resp, `AXIL_RESP_SLVERR);
		axiWrite(`REG_NOTE, 32'hFFFF_FFFF, 4'hF, resp);
		checkResp("bresp NOTE", resp, `AXIL_RESP_SLVERR);
		axiRead(4'hC, data, resp);
		checkResp("rresp 0xC", resp, `AXIL_RESP_SLVERR);
		axiRead(`REG_CONTROL, data, resp);
		checkControl("CONTROL after rejected writes", unpackControl(data), unpackControl(shadow));
		axiWrite(`REG_CONTROL, 32'h0, 4'hF, resp);
	endtask

	task automatic singleNotePlayback();
		logic [31:0] data;
		logic [1:0] resp;
		melodyPkg::noteT expNote;
		int halfCycles;
		expNote = refNote(0);
		halfCycles = expNote.halfPeriodUs * ClocksPerUs;
		toneEdges.delete();
		axiWrite(`REG_CONTROL, 32'h0000_0001, 4'hF, resp);
		checkResp("bresp CONTROL", resp, `AXIL_RESP_OKAY);
		// past the 5-cycle fetch
		waitCycles(10);
		axiRead(`REG_STATUS, data, resp);
		checkStatus("STATUS", unpackStatus(data), melodyPkg::statusT'{1'b1, 6'd0});
		axiRead(`REG_NOTE, data, resp);
		checkNote("NOTE", melodyPkg::noteT'(data), expNote);
		waitIdle(noteCycles(expNote) + 100);
		checkCycles("busy duration", busyFallCycle - busyRiseCycle, 5 + noteCycles(expNote));
		if (toneEdges.size() < 2)
			reportFailure("tone_o did not toggle during note 0");
		// first toggle one half period after the fetch, from low
		checkCycles("first tone_o toggle", toneEdges[0] - busyRiseCycle, 5 + halfCycles);
		for (int i = 1; i < toneEdges.size(); i++)
			checkCycles("tone_o toggle spacing", toneEdges[i] - toneEdges[i-1], halfCycles);
		axiRead(`REG_CONTROL, data, resp);
		checkControl("CONTROL after done", unpackControl(data), '0);
	endtask

	task automatic rangePlayback();
		logic [31:0] data;
		logic [1:0] resp;
		melodyPkg::statusT status;
		melodyPkg::noteT note;
		logic seenThird;
		logic seenFourth;
		int lastIndex;
		seenThird = 1'b0;
		seenFourth = 1'b0;
		lastIndex = 3;
		axiWrite(`REG_CONTROL, 32'h0004_0301, 4'hF, resp);
		status = '{1'b1, 6'd3};
		while (status.busy) begin
			axiRead(`REG_STATUS, data, resp);
			status = unpackStatus(data);
			if (status.busy) begin
				if (status.noteIndex < lastIndex || status.noteIndex > 4)
					reportFailure("note index left the range 3 to 4");
				lastIndex = status.noteIndex;
				axiRead(`REG_NOTE, data, resp);
				note = melodyPkg::noteT'(data);
				// during a fetch NOTE still holds the previous entry
				if (status.noteIndex == 3 && note == refNote(3))
					seenThird = 1'b1;
				else if (status.noteIndex == 3 && note != refNote(0))
					checkNote("NOTE at index 3", note, refNote(3));
				if (status.noteIndex == 4 && note == refNote(4))
					seenFourth = 1'b1;
				else if (status.noteIndex == 4 && note != refNote(3))
					checkNote("NOTE at index 4", note, refNote(4));
			end
		end
		if (!seenThird || !seenFourth)
			reportFailure("notes 3 and 4 were not both observed while polling");
		axiRead(`REG_CONTROL, data, resp);
		checkControl("CONTROL after range", unpackControl(data),
			melodyPkg::controlT'{1'b0, 1'b0, 6'd3, 6'd4});
	endtask

	task automatic loopAndStop();
		logic [31:0] data;
		logic [1:0] resp;
		melodyPkg::noteT loopNote;
		int fallsBefore;
		loopNote = refNote(8);
		fallsBefore = busyFalls;
		axiWrite(`REG_CONTROL, 32'h0008_0803, 4'hF, resp);
		waitCycles(5 + noteCycles(loopNote) + 50);
		axiRead(`REG_STATUS, data, resp);
		checkStatus("STATUS in second round", unpackStatus(data),
			melodyPkg::statusT'{1'b1, 6'd8});
		axiRead(`REG_NOTE, data, resp);
		checkNote("NOTE in second round", melodyPkg::noteT'(data), loopNote);
		checkCycles("busy falls while looping", busyFalls, fallsBefore);
		axiWrite(`REG_CONTROL, 32'h0008_0802, 4'hF, resp);
		axiRead(`REG_STATUS, data, resp);
		checkStatus("STATUS after stop", unpackStatus(data), melodyPkg::statusT'{1'b0, 6'd8});
		repeat (2 * loopNote.halfPeriodUs * ClocksPerUs) begin
			@(negedge Clock);
			checkBit("tone_o after stop", tone, 1'b0);
		end
	endtask

	initial begin
		reset = 1'b1;
		axiReq = '0;
		lcgState = 32'h082b10c3;
		repeat (2) @(posedge Clock);
		#1;
		reset = 1'b0;
		readResetValues();
		mergeControlLanes();
		singleNotePlayback();
		rangePlayback();
		loopAndStop();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
